// ==== flist.f ====
spi_ctrl_pkg.sv
spi_frame_shifter.sv
ctrl_reg_bank.sv
periph_port_gate.sv
miso_combiner.sv
spi_ctrl_top.sv
tb_spi_ctrl.sv

// ==== Bender.yml ====
package:
  name: spi_ctrl

sources:
  - spi_ctrl_pkg.sv
  - spi_frame_shifter.sv
  - ctrl_reg_bank.sv
  - periph_port_gate.sv
  - miso_combiner.sv
  - spi_ctrl_top.sv
  - target: test
    files:
      - tb_spi_ctrl.sv

// ==== tb_spi_ctrl.sv ====
module tb_spi_ctrl;

  // one table row, stimulus first, then expected results
  typedef struct packed {
    logic                                special;
    logic [4:0]                          nbits;
    logic [7:0]                          addr;
    logic [7:0]                          val;
    logic [spi_ctrl_pkg::LED_W-1:0]      exp_led;
    logic [spi_ctrl_pkg::DAC_W-1:0]      exp_dac;
    logic                                exp_rst;
    logic [15:0]                         exp_rb;
    logic [spi_ctrl_pkg::NUM_PORTS-1:0]  exp_cs_n;
  } entry_t;

  logic                               clk;
  logic                               arst_n;
  logic                               sclk;
  logic                               mosi;
  logic                               cs_n;
  logic                               special;
  logic                               miso;
  logic                               periph_sclk;
  logic                               periph_mosi;
  logic [spi_ctrl_pkg::NUM_PORTS-1:0] periph_cs_n;
  wire  [spi_ctrl_pkg::NUM_PORTS-1:0] periph_miso;
  logic [spi_ctrl_pkg::LED_W-1:0]     led;
  logic [spi_ctrl_pkg::DAC_W-1:0]     dac_ctrl;
  logic                               dac_rst;

  // bits seen on the shared peripheral bus
  logic [31:0] bus_rx;

  // reference model of the register bank
  logic [2:0] m_mux;
  logic [3:0] m_led;
  logic [2:0] m_dac;
  logic       m_rst;
  logic [7:0] m_last;

  entry_t table_q[$];
  int     n_entries = 0;

  spi_ctrl_top u_spi_ctrl_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .mosi        (mosi),
    .cs_n        (cs_n),
    .special     (special),
    .miso        (miso),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_cs_n (periph_cs_n),
    .periph_miso (periph_miso),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .dac_rst     (dac_rst)
  );

  // fixed reply per port, adc / dac / flash
  function automatic logic [15:0] port_pattern(input int k);
    case (k)
      0:       return 16'hA3C5;
      1:       return 16'h5E0B;
      default: return 16'hC7D2;
    endcase
  endfunction

  // what the master should see for a given routing
  function automatic logic [15:0] routed_pattern(input logic [2:0] mux);
    case (mux)
      3'b001:  return port_pattern(0);
      3'b010:  return port_pattern(1);
      3'b100:  return port_pattern(2);
      default: return 16'h0000;
    endcase
  endfunction

  // model value of a register, zero-extended
  function automatic logic [7:0] reg_readback(input logic [7:0] addr);
    logic [7:0] v;
    v = '0;
    case (addr)
      spi_ctrl_pkg::ADDR_LED:     v[3:0] = m_led;
      spi_ctrl_pkg::ADDR_MUX:     v[2:0] = m_mux;
      spi_ctrl_pkg::ADDR_DAC:     v[2:0] = m_dac;
      spi_ctrl_pkg::ADDR_DAC_RST: v[0]   = m_rst;
      default:                    v      = '0;
    endcase
    return v;
  endfunction

  // select setup, bits, hold, settle and the check slot, in clk cycles
  function automatic int frame_cycles(input int nbits);
    return 4 + 4 + nbits * 8 + 4 + 8 + 1;
  endfunction

  ////////////////////////////////////////
  // clock and peripheral models

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // mode 0 slave, first bit at select, next on each falling sclk
  for (genvar k = 0; k < spi_ctrl_pkg::NUM_PORTS; k++)
  begin : g_periph
    int unsigned fall_cnt = 0;
    logic [15:0] pat_sh;

    always @(negedge periph_sclk or posedge periph_cs_n[k])
    begin
      if (periph_cs_n[k])
        fall_cnt <= 0;
      else
        fall_cnt <= fall_cnt + 1;
    end

    // runs out to zero past the last bit
    assign pat_sh = port_pattern(k) << fall_cnt;
    assign periph_miso[k] = !periph_cs_n[k] && pat_sh[15];
  end

  // shared data line sampled on rising sclk, like any mode 0 slave
  always @(posedge periph_sclk)
  begin
    bus_rx <= {bus_rx[30:0], periph_mosi};
  end

  ////////////////////////////////////////
  // checker and table

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "value check did not match");
    end
  endtask

  // appends one row, expectations from the model state
  task automatic add_frame(input logic sp, input int nbits, input logic [7:0] addr,
                           input logic [7:0] val);
    entry_t e;
    int     b;
    e.special = sp;
    e.nbits   = 5'(nbits);
    e.addr    = addr;
    e.val     = val;
    // readback is latched at select, before this frame lands
    if (sp)
    begin
      e.exp_rb   = routed_pattern(m_mux);
      e.exp_cs_n = ~m_mux;
    end
    else
    begin
      e.exp_rb   = {m_last, reg_readback(m_last)};
      e.exp_cs_n = '1;
    end
    // only a full 16 bit register frame writes
    if (!sp && nbits == 16)
    begin
      case (addr)
        spi_ctrl_pkg::ADDR_MUX:
        begin
          case (val[2:0])
            3'b000, 3'b001, 3'b010, 3'b100:
            begin
              m_mux  = val[2:0];
              m_last = addr;
            end
            default:
            begin
              // several ports at once, write dropped
            end
          endcase
        end
        spi_ctrl_pkg::ADDR_LED:
        begin
          // per led, a clear request beats a set request
          for (b = 0; b < 4; b++)
          begin
            if (val[4 + b])
              m_led[b] = 1'b0;
            else if (val[b])
              m_led[b] = 1'b1;
          end
          m_last = addr;
        end
        spi_ctrl_pkg::ADDR_DAC:
        begin
          m_dac  = val[2:0];
          m_last = addr;
        end
        spi_ctrl_pkg::ADDR_DAC_RST:
        begin
          m_rst  = val[0];
          m_last = addr;
        end
        default:
        begin
          // unmapped
        end
      endcase
    end
    e.exp_led = m_led;
    e.exp_dac = m_dac;
    e.exp_rst = m_rst;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    m_mux  = '0;
    m_led  = '0;
    m_dac  = '0;
    m_rst  = 1'b0;
    m_last = '0;
    table_q.delete();
    // plain writes, first readback is zero
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_DAC, 8'h05);
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_DAC_RST, 8'h01);
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_LED, 8'h0B);
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_LED, 8'h24);
    // same bit set and cleared
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_LED, 8'h11);
    // ignored frames
    add_frame(1'b0, 16, 8'h33, 8'hFF);
    add_frame(1'b0, 15, spi_ctrl_pkg::ADDR_DAC, 8'h02);
    add_frame(1'b0, 17, spi_ctrl_pkg::ADDR_DAC, 8'h02);
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_DAC_RST, 8'h00);
    // nothing routed yet
    add_frame(1'b1, 16, 8'($urandom), 8'($urandom));
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_MUX, 8'h02);
    add_frame(1'b1, 16, 8'($urandom), 8'($urandom));
    // multi-bit mux writes leave routing and readback address alone
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_LED, 8'h00);
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_MUX, 8'h05);
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_MUX, 8'h06);
    // mux write pattern shifted while in peripheral mode
    add_frame(1'b1, 16, spi_ctrl_pkg::ADDR_MUX, 8'(1 << ($urandom % 3)));
    add_frame(1'b1, 16, spi_ctrl_pkg::ADDR_MUX, 8'(1 << ($urandom % 3)));
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_MUX, 8'h04);
    add_frame(1'b1, 16, 8'($urandom), 8'($urandom));
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_MUX, 8'h01);
    add_frame(1'b1, 16, 8'($urandom), 8'($urandom));
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_DAC, 8'hFA);
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_MUX, 8'h00);
    add_frame(1'b1, 16, 8'($urandom), 8'($urandom));
    add_frame(1'b0, 16, spi_ctrl_pkg::ADDR_DAC_RST, 8'h01);
  endtask

  ////////////////////////////////////////
  // bit-banged master, sclk = clk / 8

  task automatic run_frame(input entry_t e, output logic [31:0] rx,
                           output logic [2:0] cs_seen);
    logic [31:0] word;
    int          i;
    word    = {e.addr, e.val, 16'h0000};
    rx      = '0;
    cs_seen = '1;
    // mode settles while deselected so the gates reload
    special <= e.special;
    repeat (4) @(posedge clk);
    cs_n <= 1'b0;
    repeat (4) @(posedge clk);
    for (i = 0; i < e.nbits; i++)
    begin
      mosi <= word[31 - i];
      repeat (3) @(posedge clk);
      // sample just ahead of the rising sclk
      @(negedge clk);
      rx = {rx[30:0], miso};
      if (i == 0)
        cs_seen = periph_cs_n;
      @(posedge clk);
      sclk <= 1'b1;
      repeat (4) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (4) @(posedge clk);
    cs_n <= 1'b1;
    // register update window
    repeat (8) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // main sequence

  initial
  begin
    int unsigned seed_ret;
    int          idx;
    entry_t      e;
    logic [31:0] rx;
    logic [31:0] exp_rx;
    logic [31:0] tx_mask;
    logic [31:0] exp_tx;
    logic [2:0]  cs_seen;
    arst_n  = 1'b0;
    sclk    = 1'b0;
    mosi    = 1'b0;
    cs_n    = 1'b1;
    special = 1'b0;
    seed_ret = $urandom(32'h9099);
    build_table();
    n_entries = table_q.size();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_eq(periph_cs_n, 3'b111, "chip selects after reset");
    check_eq(led, 0, "led after reset");
    check_eq(dac_ctrl, 0, "dac_ctrl after reset");
    check_eq(dac_rst, 0, "dac_rst after reset");
    check_eq(miso, 0, "miso after reset");
    @(posedge clk);
    for (idx = 0; idx < n_entries; idx++)
    begin
      e = table_q[idx];
      run_frame(e, rx, cs_seen);
      @(negedge clk);
      // short frames see the top bits, long ones trailing zeros
      exp_rx = {e.exp_rb, 16'h0000} >> (32 - e.nbits);
      // the peripherals see every bit the master sent
      tx_mask = (32'h1 << e.nbits) - 32'h1;
      exp_tx  = {e.addr, e.val, 16'h0000} >> (32 - e.nbits);
      check_eq(cs_seen, e.exp_cs_n, $sformatf("entry %0d chip select in frame", idx));
      check_eq(rx, exp_rx, $sformatf("entry %0d miso word", idx));
      check_eq(bus_rx & tx_mask, exp_tx, $sformatf("entry %0d peripheral bus data", idx));
      check_eq(led, e.exp_led, $sformatf("entry %0d led", idx));
      check_eq(dac_ctrl, e.exp_dac, $sformatf("entry %0d dac_ctrl", idx));
      check_eq(dac_rst, e.exp_rst, $sformatf("entry %0d dac_rst", idx));
      check_eq(periph_cs_n, 3'b111, $sformatf("entry %0d chip select idle", idx));
      @(posedge clk);
    end
    $display("Regression passed");
    $finish;
  end

  // twice the longest frame per row, plus reset
  initial
  begin
    wait (n_entries > 0);
    #(n_entries * frame_cycles(17) * 2 * 40 + 400);
    $display("Timeout: the frame table did not complete in the allowed time");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== spi_ctrl_top.sv ====
module spi_ctrl_top (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                sclk,
  input  logic                                mosi,
  input  logic                                cs_n,
  input  logic                                special,
  output logic                                miso,
  output logic                                periph_sclk,
  output logic                                periph_mosi,
  output logic [spi_ctrl_pkg::NUM_PORTS-1:0]  periph_cs_n,
  input  logic [spi_ctrl_pkg::NUM_PORTS-1:0]  periph_miso,
  output logic [spi_ctrl_pkg::LED_W-1:0]      led,
  output logic [spi_ctrl_pkg::DAC_W-1:0]      dac_ctrl,
  output logic                                dac_rst
);

  // shifter to bank
  logic                     frame_valid;
  spi_ctrl_pkg::spi_frame_t frame;

  // bank to shifter
  logic [spi_ctrl_pkg::FRAME_BITS-1:0] rd_word;

  spi_ctrl_pkg::ctrl_regs_t regs;

  logic internal_miso;
  logic cs_idle;

  logic [spi_ctrl_pkg::NUM_PORTS-1:0] gated_miso;

  ////////////////////////////////////////
  // register side

  spi_frame_shifter u_shifter (
    .clk           (clk),
    .arst_n        (arst_n),
    .sclk          (sclk),
    .mosi          (mosi),
    .cs_n          (cs_n),
    .special       (special),
    .rd_word       (rd_word),
    .frame_valid   (frame_valid),
    .frame         (frame),
    .internal_miso (internal_miso),
    .cs_idle       (cs_idle)
  );

  ctrl_reg_bank u_reg_bank (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame_valid (frame_valid),
    .frame       (frame),
    .regs        (regs),
    .rd_word     (rd_word)
  );

  // board pins, dac_ctrl is {uni_bip_b, uni_bip_a, ldac}
  assign led      = regs.led;
  assign dac_ctrl = regs.dac;
  assign dac_rst  = regs.dac_rst;

  ////////////////////////////////////////
  // peripheral side

  // clock and data shared by all ports
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  // port 0 adc, 1 dac, 2 flash
  for (genvar k = 0; k < spi_ctrl_pkg::NUM_PORTS; k++)
  begin : g_port
    periph_port_gate u_gate (
      .clk         (clk),
      .arst_n      (arst_n),
      .sel         (regs.mux[k]),
      .cs_idle     (cs_idle),
      .special     (special),
      .cs_n        (cs_n),
      .periph_miso (periph_miso[k]),
      .periph_cs_n (periph_cs_n[k]),
      .gated_miso  (gated_miso[k])
    );
  end

  miso_combiner u_miso_comb (
    .special       (special),
    .internal_miso (internal_miso),
    .gated_miso    (gated_miso),
    .clk           (clk),
    .arst_n        (arst_n),
    .miso          (miso)
  );

endmodule

// ==== miso_combiner.sv ====
module miso_combiner (
  input  logic                               special,
  input  logic                               internal_miso,
  input  logic [spi_ctrl_pkg::NUM_PORTS-1:0] gated_miso,
  input  logic                               clk,
  input  logic                               arst_n,
  output logic                               miso
);

  // any enabled port, at most one drives
  logic port_miso;

  ////////////////////////////////////////
  // return path

  assign port_miso = |gated_miso;

  // register mode answers from the bank,
  // peripheral mode answers from the routed port
  always_comb
  begin
    if (special)
    begin
      miso = port_miso;
    end
    else
    begin
      miso = internal_miso;
    end
  end

  // single selected source, from bank check through port gates
  a_one_src: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(gated_miso));

endmodule

// ==== periph_port_gate.sv ====
module periph_port_gate (
  input  logic clk,
  input  logic arst_n,
  input  logic sel,
  input  logic cs_idle,
  input  logic special,
  input  logic cs_n,
  input  logic periph_miso,
  output logic periph_cs_n,
  output logic gated_miso
);

  // routing enable for this port
  logic en;

  ////////////////////////////////////////
  // enable latch

  // reload only between peripheral transactions,
  // so a mux write never cuts a live transfer
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      en <= 1'b0;
    end
    else if (cs_idle && special)
    begin
      en <= sel;
    end
  end

  ////////////////////////////////////////
  // pin gating

  // straight from the pins, keeps setup to first sclk
  assign periph_cs_n = !(en && special && !cs_n);

  // deselected ports read as zero for the or-tree
  assign gated_miso = periph_miso & en;

  // register mode must never select a peripheral
  a_cs_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    !special |-> periph_cs_n);

endmodule

// ==== ctrl_reg_bank.sv ====
module ctrl_reg_bank (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                frame_valid,
  input  spi_ctrl_pkg::spi_frame_t            frame,
  output spi_ctrl_pkg::ctrl_regs_t            regs,
  output logic [spi_ctrl_pkg::FRAME_BITS-1:0] rd_word
);

  localparam int NP = spi_ctrl_pkg::NUM_PORTS;
  localparam int LW = spi_ctrl_pkg::LED_W;
  localparam int DW = spi_ctrl_pkg::DAC_W;

  spi_ctrl_pkg::ctrl_regs_t regs_q;

  // address of the last frame that took effect
  logic [spi_ctrl_pkg::ADDR_W-1:0] last_addr;

  logic [spi_ctrl_pkg::VAL_W-1:0] rd_val;

  // mux candidate and its one-hot check
  logic [NP-1:0] mux_val;
  logic [NP-1:0] mux_low;
  logic          mux_ok;

  assign mux_val = frame.val[NP-1:0];
  assign mux_low = mux_val - 1'b1;
  assign mux_ok  = (mux_val & mux_low) == '0;

  ////////////////////////////////////////
  // write decode

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      regs_q    <= '0;
      last_addr <= '0;
    end
    else if (frame_valid)
    begin
      case (spi_ctrl_pkg::reg_addr_e'(frame.addr))
        spi_ctrl_pkg::ADDR_MUX:
        begin
          // two ports at once would fight on miso
          if (mux_ok)
          begin
            regs_q.mux <= mux_val;
            last_addr  <= frame.addr;
          end
        end
        spi_ctrl_pkg::ADDR_LED:
        begin
          // low nibble sets, high nibble clears, clear wins
          regs_q.led <= (regs_q.led | frame.val[LW-1:0]) & ~frame.val[2*LW-1:LW];
          last_addr  <= frame.addr;
        end
        spi_ctrl_pkg::ADDR_DAC:
        begin
          regs_q.dac <= frame.val[DW-1:0];
          last_addr  <= frame.addr;
        end
        spi_ctrl_pkg::ADDR_DAC_RST:
        begin
          regs_q.dac_rst <= frame.val[0];
          last_addr      <= frame.addr;
        end
        default:
        begin
          // unmapped address, nothing moves
        end
      endcase
    end
  end

  assign regs = regs_q;

  ////////////////////////////////////////
  // readback

  // current contents of the last written register
  always_comb
  begin
    rd_val = '0;
    case (spi_ctrl_pkg::reg_addr_e'(last_addr))
      spi_ctrl_pkg::ADDR_LED:     rd_val[LW-1:0] = regs_q.led;
      spi_ctrl_pkg::ADDR_MUX:     rd_val[NP-1:0] = regs_q.mux;
      spi_ctrl_pkg::ADDR_DAC:     rd_val[DW-1:0] = regs_q.dac;
      spi_ctrl_pkg::ADDR_DAC_RST: rd_val[0]      = regs_q.dac_rst;
      default:                    rd_val         = '0;
    endcase
  end

  assign rd_word = {last_addr, rd_val};

  // holds across every write sequence
  a_mux_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(regs_q.mux));

endmodule

// ==== spi_frame_shifter.sv ====
module spi_frame_shifter (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                sclk,
  input  logic                                mosi,
  input  logic                                cs_n,
  input  logic                                special,
  input  logic [spi_ctrl_pkg::FRAME_BITS-1:0] rd_word,
  output logic                                frame_valid,
  output spi_ctrl_pkg::spi_frame_t            frame,
  output logic                                internal_miso,
  output logic                                cs_idle
);

  localparam int FB = spi_ctrl_pkg::FRAME_BITS;
  localparam logic [spi_ctrl_pkg::CNT_W-1:0] FULL_CNT = spi_ctrl_pkg::CNT_W'(FB);

  // sync stages, bit order {special, cs_n, mosi, sclk}
  logic [3:0] sync_q1;
  logic [3:0] sync_q2;

  logic sclk_s;
  logic mosi_s;
  logic cs_s;
  logic special_s;

  // previous synced levels for edge detect
  logic sclk_d;
  logic cs_d;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_rise;
  logic cs_fall;

  spi_ctrl_pkg::shift_state_e state;
  logic [spi_ctrl_pkg::CNT_W-1:0] bit_cnt;

  logic [FB-1:0] in_sr;
  logic [FB-1:0] out_sr;

  ////////////////////////////////////////
  // pin sync and edges

  // cs_n resets high so nothing looks selected
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_q1 <= 4'b0100;
      sync_q2 <= 4'b0100;
      sclk_d  <= 1'b0;
      cs_d    <= 1'b1;
    end
    else
    begin
      sync_q1 <= {special, cs_n, mosi, sclk};
      sync_q2 <= sync_q1;
      sclk_d  <= sclk_s;
      cs_d    <= cs_s;
    end
  end

  assign sclk_s    = sync_q2[0];
  assign mosi_s    = sync_q2[1];
  assign cs_s      = sync_q2[2];
  assign special_s = sync_q2[3];

  assign sclk_rise = sclk_s & ~sclk_d;
  assign sclk_fall = ~sclk_s & sclk_d;
  assign cs_rise   = cs_s & ~cs_d;
  assign cs_fall   = ~cs_s & cs_d;

  // port gates only reload their enable while idle
  assign cs_idle = cs_s;

  ////////////////////////////////////////
  // frame FSM

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state       <= spi_ctrl_pkg::SH_IDLE;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      case (state)
        spi_ctrl_pkg::SH_IDLE:
        begin
          if (cs_fall)
          begin
            state   <= spi_ctrl_pkg::SH_SHIFT;
            bit_cnt <= '0;
          end
        end
        spi_ctrl_pkg::SH_SHIFT:
        begin
          if (cs_rise)
          begin
            state <= spi_ctrl_pkg::SH_IDLE;
            // exact length in register mode, else silently dropped
            frame_valid <= !special_s && (bit_cnt == FULL_CNT);
          end
          else if (sclk_rise && bit_cnt <= FULL_CNT)
          begin
            // saturates at FULL_CNT + 1
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= spi_ctrl_pkg::SH_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // data shift registers

  // mode 0, sample on rising sclk, msb first
  always_ff @(posedge clk)
  begin
    if (state == spi_ctrl_pkg::SH_SHIFT && sclk_rise)
    begin
      in_sr <= {in_sr[FB-2:0], mosi_s};
    end
  end

  assign frame = spi_ctrl_pkg::spi_frame_t'(in_sr);

  // readback word captured at select, advanced on falling sclk
  always_ff @(posedge clk)
  begin
    if (cs_fall)
    begin
      out_sr <= {rd_word[FB-2:0], 1'b0};
    end
    else if (state == spi_ctrl_pkg::SH_SHIFT && sclk_fall)
    begin
      out_sr <= {out_sr[FB-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      internal_miso <= 1'b0;
    end
    else if (cs_fall)
    begin
      // first bit goes out before any clock
      internal_miso <= rd_word[FB-1];
    end
    else if (state == spi_ctrl_pkg::SH_SHIFT && sclk_fall)
    begin
      internal_miso <= out_sr[FB-1];
    end
    else if (cs_rise)
    begin
      internal_miso <= 1'b0;
    end
  end

  // strobe only once cs_n is back high
  a_valid_idle: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |-> cs_s);

endmodule

// ==== spi_ctrl_pkg.sv ====
package spi_ctrl_pkg;

  ////////////////////////////////////////
  // sizes

  // external peripherals: adc, dac, flash
  localparam int NUM_PORTS = 3;

  // internal register frame, addr byte then value byte
  localparam int FRAME_BITS = 16;
  localparam int ADDR_W = 8;
  localparam int VAL_W = FRAME_BITS - ADDR_W;

  // bit counter, must hold FRAME_BITS + 1 for saturation
  localparam int CNT_W = 5;

  localparam int LED_W = 4;

  // uni_bip_b, uni_bip_a, ldac
  localparam int DAC_W = 3;

  // filler so the register image is a full frame wide
  localparam int PAD_W = FRAME_BITS - NUM_PORTS - LED_W - DAC_W - 1;

  ////////////////////////////////////////
  // encodings

  // register map, anything else is dropped
  typedef enum logic [ADDR_W-1:0] {
    ADDR_LED     = 8'd7,
    ADDR_MUX     = 8'd8,
    ADDR_DAC     = 8'd9,
    ADDR_DAC_RST = 8'd10
  } reg_addr_e;

  // shifter FSM
  typedef enum logic [0:0] {
    SH_IDLE  = 1'b0,
    SH_SHIFT = 1'b1
  } shift_state_e;

  ////////////////////////////////////////
  // bundles

  // one received frame, msb first on the wire
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [VAL_W-1:0]  val;
  } spi_frame_t;

  // latched register image
  typedef struct packed {
    logic [PAD_W-1:0]     pad;
    logic [NUM_PORTS-1:0] mux;
    logic [LED_W-1:0]     led;
    logic [DAC_W-1:0]     dac;
    logic                 dac_rst;
  } ctrl_regs_t;

endpackage
